/* hw/dmac_macros.svh */
// Width and depth defines for the DMA controller
`ifndef DMAC_MACROS_SVH
`define DMAC_MACROS_SVH

`default_nettype none

// Destination address and beat alignment
`define DMAC_ADDR_WIDTH 32
`define DMAC_BEAT_BYTES_WIDTH 3

// Length and stride fields
`define DMAC_LENGTH_WIDTH 24

// Transfer bookkeeping
`define DMAC_ID_WIDTH 2
`define DMAC_QUEUE_DEPTH 2

// Register bus
`define DMAC_REG_ADDR_WIDTH 9
`define DMAC_AXIL_ADDR_WIDTH 11

`default_nettype wire

`endif

/* hw/dmac_regmap_pkg.sv */
// Register word addresses, identity constants and IRQ bit positions
`include "dmac_macros.svh"
`default_nettype none

package dmac_regmap_pkg;

  typedef enum logic [`DMAC_REG_ADDR_WIDTH-1:0] {
    REG_VERSION     = 'h000,
    REG_ID          = 'h001,
    REG_SCRATCH     = 'h002,
    REG_MAGIC       = 'h003,
    REG_IRQ_MASK    = 'h020,
    REG_IRQ_PENDING = 'h021,
    REG_IRQ_SOURCE  = 'h022,
    REG_CONTROL     = 'h100,
    REG_TRANSFER_ID = 'h101,
    REG_SUBMIT      = 'h102,
    REG_DEST_ADDR   = 'h104,
    REG_X_LENGTH    = 'h106,
    REG_Y_LENGTH    = 'h107,
    REG_DEST_STRIDE = 'h108,
    REG_DONE_BITMAP = 'h10A,
    REG_EOT_ID      = 'h10B
  } reg_addr_e;

  localparam logic [31:0] CORE_VERSION = 32'h0004_0062;
  // Reads as "DMAC" in ASCII
  localparam logic [31:0] CORE_MAGIC = 32'h444D_4143;

  localparam int IRQ_SOT_BIT = 0;
  localparam int IRQ_EOT_BIT = 1;

endpackage

`default_nettype wire

/* hw/dmac_xfer_pkg.sv */
// Field types of a transfer descriptor
`include "dmac_macros.svh"
`default_nettype none

package dmac_xfer_pkg;

  typedef logic [`DMAC_ADDR_WIDTH-1:0] addr_t;
  // Holds a count minus one
  typedef logic [`DMAC_LENGTH_WIDTH-1:0] length_t;
  typedef logic [`DMAC_ID_WIDTH-1:0] transfer_id_t;

endpackage

`default_nettype wire

/* hw/dmac_ifs.sv */
// Register-access interface and transfer-request interface
`include "dmac_macros.svh"
`default_nettype none

// Strobed register requests, acknowledged one cycle later
interface dmac_up_if;
  logic wreq;
  logic [`DMAC_REG_ADDR_WIDTH-1:0] waddr;
  logic [31:0] wdata;
  logic wack;
  logic rreq;
  logic [`DMAC_REG_ADDR_WIDTH-1:0] raddr;
  logic [31:0] rdata;
  logic rack;

  modport slave_side (output wreq, waddr, wdata, rreq, raddr, input wack, rdata, rack);
  modport reg_side (input wreq, waddr, wdata, rreq, raddr, output wack, rdata, rack);
endinterface

// Transfer descriptor with valid/ready, plus the controller enable
interface dmac_req_if;
  import dmac_xfer_pkg::*;

  logic valid;
  logic ready;
  logic enable;
  addr_t dest_address;
  length_t x_length;
  length_t y_length;
  length_t dest_stride;

  modport producer (
    output valid, enable, dest_address, x_length, y_length, dest_stride,
    input ready
  );
  modport consumer (
    input valid, enable, dest_address, x_length, y_length, dest_stride,
    output ready
  );
endinterface

`default_nettype wire

/* hw/dmac_axil_slave.sv */
// AXI-lite slave producing one-cycle register write and read requests
`include "dmac_macros.svh"
`default_nettype none

module dmac_axil_slave (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  input  logic s_axi_awvalid,
  input  logic [`DMAC_AXIL_ADDR_WIDTH-1:0] s_axi_awaddr,
  output logic s_axi_awready,
  input  logic s_axi_wvalid,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0] s_axi_wstrb,
  output logic s_axi_wready,
  output logic s_axi_bvalid,
  output logic [1:0] s_axi_bresp,
  input  logic s_axi_bready,
  input  logic s_axi_arvalid,
  input  logic [`DMAC_AXIL_ADDR_WIDTH-1:0] s_axi_araddr,
  output logic s_axi_arready,
  output logic s_axi_rvalid,
  input  logic s_axi_rready,
  output logic [1:0] s_axi_rresp,
  output logic [31:0] s_axi_rdata,
  dmac_up_if.slave_side up
);

  logic w_pending;
  logic r_pending;
  logic w_accept;
  logic r_accept;
  logic [31:0] strb_mask;

  // **********************************************************************
  // Write channel

  // AW and W are taken together, only while no B response is outstanding
  assign w_accept = s_axi_awvalid & s_axi_wvalid & ~w_pending;
  assign s_axi_awready = w_accept;
  assign s_axi_wready = w_accept;
  assign s_axi_bresp = 2'b00;

  // Lanes without strobe write as zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      strb_mask[8*i +: 8] = {8{s_axi_wstrb[i]}};
    end
  end

  assign up.wreq = w_accept;
  assign up.waddr = s_axi_awaddr[`DMAC_AXIL_ADDR_WIDTH-1:2];
  assign up.wdata = s_axi_wdata & strb_mask;

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      w_pending <= 1'b0;
      s_axi_bvalid <= 1'b0;
    end else begin
      if (w_accept) begin
        w_pending <= 1'b1;
      end else if (s_axi_bvalid && s_axi_bready) begin
        w_pending <= 1'b0;
      end
      if (up.wack) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // **********************************************************************
  // Read channel

  assign r_accept = s_axi_arvalid & ~r_pending;
  assign s_axi_arready = r_accept;
  assign s_axi_rresp = 2'b00;

  assign up.rreq = r_accept;
  assign up.raddr = s_axi_araddr[`DMAC_AXIL_ADDR_WIDTH-1:2];

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      r_pending <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      if (r_accept) begin
        r_pending <= 1'b1;
      end else if (s_axi_rvalid && s_axi_rready) begin
        r_pending <= 1'b0;
      end
      if (up.rack) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  // Read word held until the master takes it
  always_ff @(posedge s_axi_aclk) begin
    if (up.rack) begin
      s_axi_rdata <= up.rdata;
    end
  end

endmodule

`default_nettype wire

/* hw/dmac_regmap.sv */
// Register file with IRQ logic, transfer submit and transfer ID tracking
`include "dmac_macros.svh"
`default_nettype none

module dmac_regmap #(
  parameter int unsigned PERIPHERAL_ID = 0
) (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  dmac_up_if.reg_side up,
  dmac_req_if.producer req,
  input  logic eot,
  output logic irq
);
  import dmac_regmap_pkg::*;
  import dmac_xfer_pkg::*;

  localparam int BEAT_W = `DMAC_BEAT_BYTES_WIDTH;
  localparam int ID_COUNT = 2 ** `DMAC_ID_WIDTH;

  logic [31:0] scratch;
  logic enable;
  logic pause;
  logic [1:0] irq_mask;
  logic [1:0] irq_source;
  logic [1:0] irq_pending;
  logic [1:0] irq_trigger;
  logic [1:0] irq_clear;
  logic req_valid;
  logic sot;
  logic [`DMAC_ADDR_WIDTH-1:BEAT_W] dest_address;
  addr_t dest_address_full;
  length_t x_length;
  length_t y_length;
  length_t dest_stride;
  transfer_id_t transfer_id;
  transfer_id_t eot_id;
  logic [ID_COUNT-1:0] done_bitmap;

  // **********************************************************************
  // Interrupts

  assign sot = req_valid & req.ready;

  always_comb begin
    irq_trigger = 2'b00;
    irq_trigger[IRQ_SOT_BIT] = sot;
    irq_trigger[IRQ_EOT_BIT] = eot;
  end

  // Writing the pending register clears source bits
  assign irq_clear = (up.wreq && up.waddr == REG_IRQ_PENDING) ? up.wdata[1:0] : 2'b00;
  assign irq_pending = irq_source & ~irq_mask;

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      irq_source <= 2'b00;
      irq <= 1'b0;
    end else begin
      irq_source <= irq_trigger | (irq_source & ~irq_clear);
      irq <= |irq_pending;
    end
  end

  // **********************************************************************
  // Register writes and submit

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      scratch <= '0;
      enable <= 1'b0;
      pause <= 1'b0;
      irq_mask <= 2'b11;
      req_valid <= 1'b0;
      dest_address <= '0;
      x_length <= '0;
      y_length <= '0;
      dest_stride <= '0;
      up.wack <= 1'b0;
    end else begin
      up.wack <= up.wreq;
      if (!enable) begin
        req_valid <= 1'b0;
      end else if (up.wreq && up.waddr == REG_SUBMIT) begin
        req_valid <= req_valid | up.wdata[0];
      end else if (sot) begin
        req_valid <= 1'b0;
      end

      if (up.wreq) begin
        case (up.waddr)
          REG_SCRATCH: scratch <= up.wdata;
          REG_IRQ_MASK: irq_mask <= up.wdata[1:0];
          REG_CONTROL: {pause, enable} <= up.wdata[1:0];
          REG_DEST_ADDR: dest_address <= up.wdata[`DMAC_ADDR_WIDTH-1:BEAT_W];
          REG_X_LENGTH: x_length <= up.wdata[`DMAC_LENGTH_WIDTH-1:0];
          REG_Y_LENGTH: y_length <= up.wdata[`DMAC_LENGTH_WIDTH-1:0];
          REG_DEST_STRIDE: dest_stride <= up.wdata[`DMAC_LENGTH_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // Beat-aligned, low bits always zero
  assign dest_address_full = {dest_address, {BEAT_W{1'b0}}};

  assign req.valid = req_valid;
  assign req.enable = enable;
  assign req.dest_address = dest_address_full;
  assign req.x_length = x_length;
  assign req.y_length = y_length;
  assign req.dest_stride = dest_stride;

  // **********************************************************************
  // Register reads

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      up.rack <= 1'b0;
    end else begin
      up.rack <= up.rreq;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (up.rreq) begin
      case (up.raddr)
        REG_VERSION: up.rdata <= CORE_VERSION;
        REG_ID: up.rdata <= 32'(PERIPHERAL_ID);
        REG_SCRATCH: up.rdata <= scratch;
        REG_MAGIC: up.rdata <= CORE_MAGIC;
        REG_IRQ_MASK: up.rdata <= {30'd0, irq_mask};
        REG_IRQ_PENDING: up.rdata <= {30'd0, irq_pending};
        REG_IRQ_SOURCE: up.rdata <= {30'd0, irq_source};
        REG_CONTROL: up.rdata <= {30'd0, pause, enable};
        REG_TRANSFER_ID: up.rdata <= 32'(transfer_id);
        REG_SUBMIT: up.rdata <= {31'd0, req_valid};
        REG_DEST_ADDR: up.rdata <= 32'(dest_address_full);
        REG_X_LENGTH: up.rdata <= 32'(x_length);
        REG_Y_LENGTH: up.rdata <= 32'(y_length);
        REG_DEST_STRIDE: up.rdata <= 32'(dest_stride);
        REG_DONE_BITMAP: up.rdata <= 32'(done_bitmap);
        REG_EOT_ID: up.rdata <= 32'(eot_id);
        default: up.rdata <= '0;
      endcase
    end
  end

  // **********************************************************************
  // Transfer IDs and done bitmap, cleared while disabled

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !enable) begin
      transfer_id <= '0;
      eot_id <= '0;
      done_bitmap <= '0;
    end else begin
      if (sot) begin
        transfer_id <= transfer_id + 1'b1;
        done_bitmap[transfer_id] <= 1'b0;
      end
      if (eot) begin
        done_bitmap[eot_id] <= 1'b1;
        eot_id <= eot_id + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dmac_req_queue.sv */
// FIFO of submitted transfer descriptors
`include "dmac_macros.svh"
`default_nettype none

module dmac_req_queue #(
  parameter int DEPTH = `DMAC_QUEUE_DEPTH
) (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  input  logic enable,
  dmac_req_if.consumer in,
  dmac_req_if.producer out
);
  import dmac_xfer_pkg::*;

  // DEPTH must be a power of two, at least 2
  localparam int PTR_W = $clog2(DEPTH);

  typedef struct packed {
    addr_t dest_address;
    length_t x_length;
    length_t y_length;
    length_t dest_stride;
  } entry_t;

  entry_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;
  logic push;
  logic pop;

  assign in.ready = (count != (PTR_W + 1)'(DEPTH));
  assign push = in.valid & in.ready;
  assign pop = out.valid & out.ready;

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !enable) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= '{in.dest_address, in.x_length, in.y_length, in.dest_stride};
    end
  end

  assign out.valid = (count != '0);
  assign out.enable = enable;
  assign out.dest_address = mem[rd_ptr].dest_address;
  assign out.x_length = mem[rd_ptr].x_length;
  assign out.y_length = mem[rd_ptr].y_length;
  assign out.dest_stride = mem[rd_ptr].dest_stride;

endmodule

`default_nettype wire

/* hw/dmac_2d_transfer.sv */
// 2D engine splitting a transfer into row requests and counting row completions
`default_nettype none

module dmac_2d_transfer (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  dmac_req_if.consumer req,
  output logic row_valid,
  output dmac_xfer_pkg::addr_t row_address,
  output dmac_xfer_pkg::length_t row_length,
  output logic row_last,
  input  logic row_ready,
  input  logic row_done,
  output logic eot
);
  import dmac_xfer_pkg::*;

  logic busy;
  logic take;
  length_t rows_left;
  length_t done_left;
  length_t stride;

  // Next entry is taken as soon as the previous one has ended
  assign req.ready = ~busy;
  assign take = req.valid & ~busy;

  // Control state, dropped when the controller is disabled
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !req.enable) begin
      busy <= 1'b0;
      row_valid <= 1'b0;
      eot <= 1'b0;
    end else begin
      eot <= 1'b0;
      if (take) begin
        busy <= 1'b1;
        row_valid <= 1'b1;
      end else if (row_valid && row_ready && row_last) begin
        row_valid <= 1'b0;
      end
      // Last completion ends the transfer
      if (busy && row_done && done_left == '0) begin
        busy <= 1'b0;
        eot <= 1'b1;
      end
    end
  end

  // Row fields and counters
  always_ff @(posedge s_axi_aclk) begin
    if (take) begin
      row_address <= req.dest_address;
      row_length <= req.x_length;
      row_last <= (req.y_length == '0);
      rows_left <= req.y_length;
      done_left <= req.y_length;
      stride <= req.dest_stride;
    end else begin
      if (row_valid && row_ready && !row_last) begin
        row_address <= row_address + addr_t'(stride);
        rows_left <= rows_left - 1'b1;
        row_last <= (rows_left == length_t'(1));
      end
      if (busy && row_done && done_left != '0) begin
        done_left <= done_left - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dmac_top.sv */
// DMA controller top level with AXI-lite, IRQ and row request ports
`include "dmac_macros.svh"
`default_nettype none

module dmac_top #(
  parameter int unsigned PERIPHERAL_ID = 0
) (
  input  logic s_axi_aclk,
  input  logic s_axi_aresetn,
  input  logic s_axi_awvalid,
  input  logic [`DMAC_AXIL_ADDR_WIDTH-1:0] s_axi_awaddr,
  output logic s_axi_awready,
  input  logic s_axi_wvalid,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0] s_axi_wstrb,
  output logic s_axi_wready,
  output logic s_axi_bvalid,
  output logic [1:0] s_axi_bresp,
  input  logic s_axi_bready,
  input  logic s_axi_arvalid,
  input  logic [`DMAC_AXIL_ADDR_WIDTH-1:0] s_axi_araddr,
  output logic s_axi_arready,
  output logic s_axi_rvalid,
  input  logic s_axi_rready,
  output logic [1:0] s_axi_rresp,
  output logic [31:0] s_axi_rdata,
  output logic irq,
  output logic row_valid,
  output dmac_xfer_pkg::addr_t row_address,
  output dmac_xfer_pkg::length_t row_length,
  output logic row_last,
  input  logic row_ready,
  input  logic row_done
);

  dmac_up_if up_bus ();
  dmac_req_if submit_bus ();
  dmac_req_if queue_bus ();
  logic eot;

  dmac_axil_slave i_axil_slave (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awaddr(s_axi_awaddr),
    .s_axi_awready(s_axi_awready),
    .s_axi_wvalid(s_axi_wvalid),
    .s_axi_wdata(s_axi_wdata),
    .s_axi_wstrb(s_axi_wstrb),
    .s_axi_wready(s_axi_wready),
    .s_axi_bvalid(s_axi_bvalid),
    .s_axi_bresp(s_axi_bresp),
    .s_axi_bready(s_axi_bready),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_araddr(s_axi_araddr),
    .s_axi_arready(s_axi_arready),
    .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rready(s_axi_rready),
    .s_axi_rresp(s_axi_rresp),
    .s_axi_rdata(s_axi_rdata),
    .up(up_bus)
  );

  dmac_regmap #(
    .PERIPHERAL_ID(PERIPHERAL_ID)
  ) i_regmap (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .up(up_bus),
    .req(submit_bus),
    .eot(eot),
    .irq(irq)
  );

  // Enable travels with the submit requests
  dmac_req_queue i_req_queue (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .enable(submit_bus.enable),
    .in(submit_bus),
    .out(queue_bus)
  );

  dmac_2d_transfer i_2d_transfer (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .req(queue_bus),
    .row_valid(row_valid),
    .row_address(row_address),
    .row_length(row_length),
    .row_last(row_last),
    .row_ready(row_ready),
    .row_done(row_done),
    .eot(eot)
  );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
// Testbench clock and reset generator
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD = 50,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset released on a falling edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/dmac_asserts.sv */
// Concurrent assertions on the row, B, R and IRQ outputs of the DMA controller
`default_nettype none

module dmac_asserts (
  input logic s_axi_aclk,
  input logic s_axi_aresetn,
  input logic s_axi_bvalid,
  input logic s_axi_bready,
  input logic s_axi_rvalid,
  input logic s_axi_rready,
  input logic [31:0] s_axi_rdata,
  input logic irq,
  input logic row_valid,
  input logic row_ready,
  input dmac_xfer_pkg::addr_t row_address,
  input dmac_xfer_pkg::length_t row_length,
  input logic row_last
);

  // Row request held with all fields until row_ready
  row_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    row_valid && !row_ready |=> row_valid && $stable(row_address)
      && $stable(row_length) && $stable(row_last))
    else $error("row request changed before row_ready");

  b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else $error("rvalid or rdata changed before rready");

  // Each reset edge clears the irq register
  irq_reset: assert property (@(posedge s_axi_aclk)
    !s_axi_aresetn |=> !irq)
    else $error("irq high during reset");

endmodule

`default_nettype wire

/* verif/tb_dmac.sv */
// DMA controller testbench: bus tasks, row responder, directed tests, checks and watchdog
`include "dmac_macros.svh"
`default_nettype none

module tb_dmac;
  import dmac_regmap_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int unsigned TB_PERIPHERAL_ID = 32'h0000_005A;

  logic s_axi_aclk;
  logic s_axi_aresetn;
  logic s_axi_awvalid;
  logic [`DMAC_AXIL_ADDR_WIDTH-1:0] s_axi_awaddr;
  logic s_axi_awready;
  logic s_axi_wvalid;
  logic [31:0] s_axi_wdata;
  logic [3:0] s_axi_wstrb;
  logic s_axi_wready;
  logic s_axi_bvalid;
  logic [1:0] s_axi_bresp;
  logic s_axi_bready;
  logic s_axi_arvalid;
  logic [`DMAC_AXIL_ADDR_WIDTH-1:0] s_axi_araddr;
  logic s_axi_arready;
  logic s_axi_rvalid;
  logic s_axi_rready;
  logic [1:0] s_axi_rresp;
  logic [31:0] s_axi_rdata;
  logic irq;
  logic row_valid;
  logic [`DMAC_ADDR_WIDTH-1:0] row_address;
  logic [`DMAC_LENGTH_WIDTH-1:0] row_length;
  logic row_last;
  logic row_ready;
  logic row_done;

  integer seed = 32'hd57a;

  // Rows taken at the row port, and rows predicted from the programmed registers
  logic [31:0] seen_addr_q[$];
  logic [31:0] seen_len_q[$];
  logic seen_last_q[$];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_len_q[$];
  logic exp_last_q[$];

  tb_clkgen clkgen (
    .clk(s_axi_aclk),
    .rst_n(s_axi_aresetn)
  );

  dmac_top #(
    .PERIPHERAL_ID(TB_PERIPHERAL_ID)
  ) DUT (.*);

  bind dmac_top dmac_asserts asserts_i (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .s_axi_bvalid(s_axi_bvalid),
    .s_axi_bready(s_axi_bready),
    .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rready(s_axi_rready),
    .s_axi_rdata(s_axi_rdata),
    .irq(irq),
    .row_valid(row_valid),
    .row_ready(row_ready),
    .row_address(row_address),
    .row_length(row_length),
    .row_last(row_last)
  );

  // **********************************************************************
  // Failure reporting and checks

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      end_with_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                 name, actual, expected));
    end
  endtask

  // **********************************************************************
  // AXI-lite master tasks

  // Request held until its ready, response left waiting one cycle before it is taken
  task automatic axil_write(input logic [`DMAC_REG_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] data);
    @(negedge s_axi_aclk);
    s_axi_awaddr = {addr, 2'b00};
    s_axi_wdata = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid = 1'b1;
    do @(posedge s_axi_aclk); while (!s_axi_awready);
    check_value("s_axi_wready", 32'(s_axi_wready), 32'h1);
    @(negedge s_axi_aclk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    while (!s_axi_bvalid) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    s_axi_bready = 1'b1;
    check_value("s_axi_bresp", 32'(s_axi_bresp), 32'h0);
    @(negedge s_axi_aclk);
    s_axi_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [`DMAC_REG_ADDR_WIDTH-1:0] addr,
                           output logic [31:0] data);
    @(negedge s_axi_aclk);
    s_axi_araddr = {addr, 2'b00};
    s_axi_arvalid = 1'b1;
    do @(posedge s_axi_aclk); while (!s_axi_arready);
    @(negedge s_axi_aclk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge s_axi_aclk);
    @(negedge s_axi_aclk);
    data = s_axi_rdata;
    s_axi_rready = 1'b1;
    check_value("s_axi_rresp", 32'(s_axi_rresp), 32'h0);
    @(negedge s_axi_aclk);
    s_axi_rready = 1'b0;
  endtask

  task automatic read_check(input logic [`DMAC_REG_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] expected, input string name);
    logic [31:0] value;
    axil_read(addr, value);
    check_value(name, value, expected);
  endtask

  // **********************************************************************
  // Transfer helpers

  // Rows start at the beat-aligned address and step by the stride
  task automatic expect_rows(input logic [31:0] dest, input logic [31:0] xlen,
                             input logic [31:0] ylen, input logic [31:0] stride);
    logic [31:0] addr;
    addr = {dest[31:3], 3'b000};
    for (int k = 0; k <= int'(ylen); k++) begin
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(xlen);
      exp_last_q.push_back(k == int'(ylen));
      addr = addr + stride;
    end
  endtask

  task automatic submit_transfer(input logic [31:0] dest, input logic [31:0] xlen,
                                 input logic [31:0] ylen, input logic [31:0] stride);
    axil_write(REG_DEST_ADDR, dest);
    axil_write(REG_X_LENGTH, xlen);
    axil_write(REG_Y_LENGTH, ylen);
    axil_write(REG_DEST_STRIDE, stride);
    expect_rows(dest, xlen, ylen, stride);
    axil_write(REG_SUBMIT, 32'h1);
  endtask

  // IDs, done bitmap and queue start from zero, IRQ sources cleared
  task automatic restart_controller();
    axil_write(REG_CONTROL, 32'h0);
    axil_write(REG_CONTROL, 32'h1);
    axil_write(REG_IRQ_PENDING, 32'h3);
  endtask

  task automatic wait_eot_id(input logic [31:0] expected);
    logic [31:0] value;
    do axil_read(REG_EOT_ID, value); while (value !== expected);
  endtask

  task automatic wait_irq(input logic level);
    while (irq !== level) @(negedge s_axi_aclk);
  endtask

  task automatic check_rows();
    check_value("row count", 32'(seen_addr_q.size()), 32'(exp_addr_q.size()));
    foreach (exp_addr_q[i]) begin
      check_value($sformatf("row_address[%0d]", i), seen_addr_q[i], exp_addr_q[i]);
      check_value($sformatf("row_length[%0d]", i), seen_len_q[i], exp_len_q[i]);
      check_value($sformatf("row_last[%0d]", i), 32'(seen_last_q[i]), 32'(exp_last_q[i]));
    end
    seen_addr_q.delete();
    seen_len_q.delete();
    seen_last_q.delete();
    exp_addr_q.delete();
    exp_len_q.delete();
    exp_last_q.delete();
  endtask

  // **********************************************************************
  // Tests

  task automatic test_reset_identity();
    check_value("irq", 32'(irq), 32'h0);
    check_value("row_valid", 32'(row_valid), 32'h0);
    read_check(REG_VERSION, 32'h0004_0062, "version");
    read_check(REG_MAGIC, 32'h444D_4143, "magic");
    read_check(REG_ID, TB_PERIPHERAL_ID, "peripheral id");
    read_check(REG_IRQ_MASK, 32'h3, "irq mask");
    axil_write(REG_SCRATCH, 32'hA5A5_5A5A);
    read_check(REG_SCRATCH, 32'hA5A5_5A5A, "scratch");
    axil_write(REG_SCRATCH, 32'h0123_4567);
    read_check(REG_SCRATCH, 32'h0123_4567, "scratch");
    read_check(9'h050, 32'h0, "unmapped");
  endtask

  task automatic test_programming_readback();
    axil_write(REG_DEST_ADDR, 32'h1234_567F);
    read_check(REG_DEST_ADDR, 32'h1234_5678, "dest address");
    axil_write(REG_X_LENGTH, 32'h00AB_CDEF);
    read_check(REG_X_LENGTH, 32'h00AB_CDEF, "x length");
    axil_write(REG_Y_LENGTH, 32'h0000_0123);
    read_check(REG_Y_LENGTH, 32'h0000_0123, "y length");
    axil_write(REG_DEST_STRIDE, 32'h0000_4000);
    read_check(REG_DEST_STRIDE, 32'h0000_4000, "dest stride");
    // Pause alone, enable off
    axil_write(REG_CONTROL, 32'h2);
    read_check(REG_CONTROL, 32'h2, "control");
    axil_write(REG_CONTROL, 32'h0);
  endtask

  task automatic test_row_generation();
    restart_controller();
    submit_transfer(32'h8000_0105, 32'd63, 32'd5, 32'h0000_0200);
    wait_eot_id(32'h1);
    check_rows();
  endtask

  task automatic test_completion_ids();
    restart_controller();
    submit_transfer(32'h0000_2000, 32'd15, 32'd2, 32'h0000_0100);
    wait_eot_id(32'h1);
    check_rows();
    read_check(REG_EOT_ID, 32'h1, "eot id");
    read_check(REG_DONE_BITMAP, 32'h1, "done bitmap");
    read_check(REG_TRANSFER_ID, 32'h1, "transfer id");
    read_check(REG_IRQ_SOURCE, 32'h3, "irq source");
  endtask

  task automatic test_interrupts();
    restart_controller();
    axil_write(REG_IRQ_MASK, 32'h0);
    submit_transfer(32'h0000_4000, 32'd7, 32'd1, 32'h0000_0080);
    wait_eot_id(32'h1);
    wait_irq(1'b1);
    check_rows();
    read_check(REG_IRQ_PENDING, 32'h3, "irq pending");
    axil_write(REG_IRQ_PENDING, 32'h3);
    wait_irq(1'b0);
    read_check(REG_IRQ_SOURCE, 32'h0, "irq source");
    // Masked sources still latch but never reach irq
    axil_write(REG_IRQ_MASK, 32'h3);
    submit_transfer(32'h0000_5000, 32'd7, 32'd2, 32'h0000_0080);
    wait_eot_id(32'h2);
    check_rows();
    read_check(REG_IRQ_SOURCE, 32'h3, "irq source");
    read_check(REG_IRQ_PENDING, 32'h0, "irq pending");
    check_value("irq", 32'(irq), 32'h0);
  endtask

  task automatic test_queued_transfers();
    restart_controller();
    submit_transfer(32'h0001_0000, 32'd15, 32'd2, 32'h0000_0040);
    submit_transfer(32'h0002_0000, 32'd31, 32'd3, 32'h0000_0100);
    read_check(REG_TRANSFER_ID, 32'h2, "transfer id");
    wait_eot_id(32'h2);
    check_rows();
    read_check(REG_DONE_BITMAP, 32'h3, "done bitmap");
  endtask

  // **********************************************************************
  // Row responder standing in for the data mover

  initial begin : row_responder
    integer rnd;
    int outstanding;
    outstanding = 0;
    row_ready = 1'b0;
    row_done = 1'b0;
    forever begin
      @(negedge s_axi_aclk);
      if (!s_axi_aresetn) begin
        row_ready = 1'b0;
        row_done = 1'b0;
      end else begin
        rnd = $random(seed);
        // Completions only for rows already handed over
        if (outstanding > 0 && rnd[2]) begin
          row_done = 1'b1;
          outstanding = outstanding - 1;
        end else begin
          row_done = 1'b0;
        end
        row_ready = rnd[0] | rnd[1];
        // Handshake happens at the coming rising edge
        if (row_valid && row_ready) begin
          seen_addr_q.push_back(row_address);
          seen_len_q.push_back(32'(row_length));
          seen_last_q.push_back(row_last);
          outstanding = outstanding + 1;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge s_axi_aclk);
    end_with_failure("timeout waiting for DUT");
  end

  initial begin
    s_axi_awvalid = 1'b0;
    s_axi_awaddr = '0;
    s_axi_wvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = 4'hF;
    s_axi_bready = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr = '0;
    s_axi_rready = 1'b0;
    @(posedge s_axi_aresetn);
    @(negedge s_axi_aclk);
    test_reset_identity();
    test_programming_readback();
    test_row_generation();
    test_completion_ids();
    test_interrupts();
    test_queued_transfers();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/dmac_regmap_pkg.sv
hw/dmac_xfer_pkg.sv
hw/dmac_ifs.sv
hw/dmac_axil_slave.sv
hw/dmac_regmap.sv
hw/dmac_req_queue.sv
hw/dmac_2d_transfer.sv
hw/dmac_top.sv
verif/tb_clkgen.sv
verif/dmac_asserts.sv
verif/tb_dmac.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dmac
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
